// ==== hw/neuron_pkg.sv ====
package neuron_pkg;

	// network size.
	localparam int n_terms = 15;
	localparam int idx_w = 4;

	// register map.
	localparam logic [7:0] reg_act_base = 8'h00;
	localparam logic [7:0] reg_ctrl = 8'h40;
	localparam logic [7:0] reg_status = 8'h44;
	localparam logic [7:0] reg_result = 8'h48;

	// ieee-754 single precision word.
	typedef struct packed {
		logic sign;
		logic [7:0] exp;
		logic [22:0] mant;
	} fp32_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [7:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

endpackage

// ==== hw/fp_mult.sv ====
`timescale 1ns/1ps

module fp_mult (
	input  logic clk,
	input  logic rst_n,
	input  logic mul_en,
	input  neuron_pkg::fp32_t a,
	input  neuron_pkg::fp32_t b,
	output neuron_pkg::fp32_t product,
	output logic mul_valid
);

	logic [47:0] sig_prod;
	logic signed [9:0] exp_sum;
	logic signed [9:0] exp_norm;
	logic [22:0] mant_norm;
	neuron_pkg::fp32_t res;

	assign sig_prod = {1'b1, a.mant} * {1'b1, b.mant};
	assign exp_sum = $signed({2'b00, a.exp}) + $signed({2'b00, b.exp}) - 10'sd127;

	// product of two 1.x values lies in [1, 4).
	always_comb
	begin
		if (sig_prod[47])
		begin
			mant_norm = sig_prod[46:24];
			exp_norm = exp_sum + 10'sd1;
		end
		else
		begin
			mant_norm = sig_prod[45:23];
			exp_norm = exp_sum;
		end
	end

	always_comb
	begin
		res.sign = a.sign ^ b.sign;
		if (a.exp == 8'd0 || b.exp == 8'd0 || exp_norm <= 10'sd0)
		begin
			// zero, denormal or underflow.
			res.exp = 8'd0;
			res.mant = 23'd0;
		end
		else if (exp_norm >= 10'sd255)
		begin
			res.exp = 8'hff;
			res.mant = 23'd0;
		end
		else
		begin
			res.exp = exp_norm[7:0];
			res.mant = mant_norm;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			mul_valid <= 1'b0;
		else
			mul_valid <= mul_en;
	end

	always_ff @(posedge clk)
	begin
		if (mul_en)
			product <= res;
	end

	assert property (@(posedge clk) disable iff (!rst_n) mul_valid |-> $past(mul_en))
		else $error("fp_mult: valid raised without an enable");

endmodule

// ==== hw/fp_add.sv ====
`timescale 1ns/1ps

module fp_add (
	input  logic clk,
	input  logic rst_n,
	input  logic add_en,
	input  neuron_pkg::fp32_t a,
	input  neuron_pkg::fp32_t b,
	output neuron_pkg::fp32_t sum,
	output logic add_valid
);

	neuron_pkg::fp32_t big;
	neuron_pkg::fp32_t lesser;
	logic [23:0] sig_big;
	logic [23:0] sig_small;
	logic [23:0] sig_shift;
	logic [7:0] exp_diff;
	logic [24:0] sig_sum;
	logic [4:0] lz;
	logic [23:0] sig_norm;
	logic signed [9:0] exp_norm;
	neuron_pkg::fp32_t res;

	function automatic logic [4:0] lead_zeros(input logic [23:0] v);
		logic [4:0] n;
		n = 5'd24;
		// highest set bit wins.
		for (int i = 0; i < 24; i++)
		begin
			if (v[i])
				n = 5'(23 - i);
		end
		return n;
	endfunction

	always_comb
	begin
		if ({a.exp, a.mant} >= {b.exp, b.mant})
		begin
			big = a;
			lesser = b;
		end
		else
		begin
			big = b;
			lesser = a;
		end
	end

	// denormals count as zero.
	assign sig_big = (big.exp == 8'd0) ? 24'd0 : {1'b1, big.mant};
	assign sig_small = (lesser.exp == 8'd0) ? 24'd0 : {1'b1, lesser.mant};
	assign exp_diff = big.exp - lesser.exp;
	assign sig_shift = sig_small >> exp_diff;

	assign sig_sum = (big.sign == lesser.sign) ?
		{1'b0, sig_big} + {1'b0, sig_shift} :
		{1'b0, sig_big} - {1'b0, sig_shift};

	assign lz = lead_zeros(sig_sum[23:0]);
	assign sig_norm = sig_sum[23:0] << lz;
	assign exp_norm = $signed({2'b00, big.exp}) - $signed({5'b00000, lz});

	always_comb
	begin
		res = '0;
		if (big.exp == 8'hff)
			res = big;
		else if (sig_sum[24])
		begin
			res.sign = big.sign;
			if (big.exp == 8'hfe)
				res.exp = 8'hff;
			else
			begin
				res.exp = big.exp + 8'd1;
				res.mant = sig_sum[23:1];
			end
		end
		else if (sig_sum[23:0] != 24'd0 && exp_norm > 10'sd0)
		begin
			res.sign = big.sign;
			res.exp = exp_norm[7:0];
			res.mant = sig_norm[22:0];
		end
		// underflow keeps the sign.
		else if (sig_sum[23:0] != 24'd0)
			res.sign = big.sign;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			add_valid <= 1'b0;
		else
			add_valid <= add_en;
	end

	always_ff @(posedge clk)
	begin
		if (add_en)
			sum <= res;
	end

	assert property (@(posedge clk) disable iff (!rst_n) add_en |=> add_valid)
		else $error("fp_add: valid missing one cycle after enable");

endmodule

// ==== hw/weight_rom.sv ====
`timescale 1ns/1ps

module weight_rom (
	input  logic [neuron_pkg::idx_w-1:0] term_idx,
	output neuron_pkg::fp32_t weight,
	output neuron_pkg::fp32_t bias
);

	assign bias = 32'b00111110000000100111010000110001;

	always_comb
	begin
		case (term_idx)
			4'd0: weight = 32'b10111110011100011011100000010100;
			4'd1: weight = 32'b00111110100111010111000110101000;
			4'd2: weight = 32'b10111101010101110001011111001001;
			4'd3: weight = 32'b10111110100011001001011110001100;
			4'd4: weight = 32'b00111110100001100000101000000111;
			4'd5: weight = 32'b00111111000111001000010010000010;
			4'd6: weight = 32'b00111110011011101101101100001100;
			4'd7: weight = 32'b00111110010100001110100101111000;
			4'd8: weight = 32'b00111110101100000001100101000011;
			4'd9: weight = 32'b10111110000110101000000111110010;
			4'd10: weight = 32'b10111110111011011010011101000001;
			4'd11: weight = 32'b10111101111001010110010000000110;
			4'd12: weight = 32'b10111110101100000011111011001111;
			4'd13: weight = 32'b00111111000101001010111001011001;
			4'd14: weight = 32'b00111111000001001101111001110110;
			default: weight = '0;
		endcase
	end

endmodule

// ==== hw/neuron_apb_regs.sv ====
`timescale 1ns/1ps

module neuron_apb_regs (
	input  logic clk,
	input  logic rst_n,
	input  neuron_pkg::apb_req_t apb_req,
	output neuron_pkg::apb_rsp_t apb_rsp,
	input  logic busy,
	input  logic done,
	input  neuron_pkg::fp32_t result,
	output logic start,
	output neuron_pkg::fp32_t [neuron_pkg::n_terms-1:0] acts
);

	logic access;
	logic wr;
	logic rd;
	logic [7:0] act_off;
	logic [neuron_pkg::idx_w-1:0] act_idx;
	logic act_hit;
	logic ctrl_hit;
	logic status_hit;
	logic result_hit;
	logic mapped;
	logic locked;
	logic err;

	// no wait states, so every access phase completes.
	assign access = apb_req.psel & apb_req.penable;
	assign wr = access & apb_req.pwrite;
	assign rd = access & ~apb_req.pwrite;

	assign act_off = apb_req.paddr - neuron_pkg::reg_act_base;
	assign act_idx = act_off[neuron_pkg::idx_w+1:2];
	assign act_hit = (act_off[1:0] == 2'b00) && (int'(act_off[7:2]) < neuron_pkg::n_terms);
	assign ctrl_hit = (apb_req.paddr == neuron_pkg::reg_ctrl);
	assign status_hit = (apb_req.paddr == neuron_pkg::reg_status);
	assign result_hit = (apb_req.paddr == neuron_pkg::reg_result);
	assign mapped = act_hit | ctrl_hit | status_hit | result_hit;

	// inputs and control are frozen while running.
	assign locked = busy & (act_hit | ctrl_hit);
	assign err = ~mapped | (apb_req.pwrite & locked);

	assign start = wr & ctrl_hit & apb_req.pwdata[0] & ~busy;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			acts <= '0;
		else if (wr && act_hit && !busy)
			acts[act_idx] <= apb_req.pwdata;
	end

	always_comb
	begin
		apb_rsp.prdata = 32'd0;
		apb_rsp.pready = 1'b1;
		apb_rsp.pslverr = access & err;
		if (rd)
		begin
			if (act_hit)
				apb_rsp.prdata = acts[act_idx];
			else if (status_hit)
				apb_rsp.prdata = {30'd0, done, busy};
			else if (result_hit)
				apb_rsp.prdata = result;
		end
	end

	// controller must pick up every start.
	assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy ##1 (busy && !done))
		else $error("neuron_apb_regs: start not taken by the controller");

endmodule

// ==== hw/neuron_ctrl.sv ====
`timescale 1ns/1ps

module neuron_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  neuron_pkg::fp32_t [neuron_pkg::n_terms-1:0] acts,
	output logic [neuron_pkg::idx_w-1:0] term_idx,
	input  neuron_pkg::fp32_t weight,
	input  neuron_pkg::fp32_t bias,
	output neuron_pkg::fp32_t mul_a,
	output neuron_pkg::fp32_t mul_b,
	output logic mul_en,
	input  neuron_pkg::fp32_t product,
	input  logic mul_valid,
	output neuron_pkg::fp32_t add_a,
	output neuron_pkg::fp32_t add_b,
	output logic add_en,
	input  neuron_pkg::fp32_t sum,
	input  logic add_valid,
	output logic busy,
	output logic done,
	output neuron_pkg::fp32_t result
);

	logic launch;
	logic issue;
	logic mul_last;
	logic first_add;
	logic [neuron_pkg::idx_w-1:0] add_cnt;

	assign launch = start & ~busy;
	// next product goes out alongside the current add.
	assign issue = launch | (busy & mul_valid & ~mul_last);

	// adder output is the running sum, seeded with the bias.
	assign add_en = busy & mul_valid;
	assign add_a = first_add ? bias : sum;
	assign add_b = product;

	always_ff @(posedge clk)
	begin
		if (issue)
		begin
			mul_a <= acts[term_idx];
			mul_b <= weight;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			busy <= 1'b0;
			done <= 1'b0;
			result <= '0;
			mul_en <= 1'b0;
			term_idx <= '0;
			mul_last <= 1'b0;
			first_add <= 1'b0;
			add_cnt <= '0;
		end
		else
		begin
			mul_en <= issue;
			if (launch)
			begin
				busy <= 1'b1;
				done <= 1'b0;
				first_add <= 1'b1;
				mul_last <= 1'b0;
				add_cnt <= '0;
				term_idx <= term_idx + 1'b1;
			end
			else if (busy)
			begin
				if (issue && int'(term_idx) == neuron_pkg::n_terms - 1)
					mul_last <= 1'b1;
				else if (issue)
					term_idx <= term_idx + 1'b1;
				if (add_en)
					first_add <= 1'b0;
				if (add_valid)
					add_cnt <= add_cnt + 1'b1;
				if (add_valid && int'(add_cnt) == neuron_pkg::n_terms - 1)
				begin
					// relu clears negative zero as well.
					busy <= 1'b0;
					done <= 1'b1;
					term_idx <= '0;
					result <= sum.sign ? neuron_pkg::fp32_t'('0) : sum;
				end
			end
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) mul_en |-> busy)
		else $error("neuron_ctrl: multiply issued while idle");

	assert property (@(posedge clk) disable iff (!rst_n)
		busy |-> int'(term_idx) < neuron_pkg::n_terms)
		else $error("neuron_ctrl: term index out of range");

endmodule

// ==== hw/neuron_top.sv ====
`timescale 1ns/1ps

module neuron_top (
	input  logic clk,
	input  logic rst_n,
	input  neuron_pkg::apb_req_t apb_req,
	output neuron_pkg::apb_rsp_t apb_rsp
);

	logic start;
	logic busy;
	logic done;
	neuron_pkg::fp32_t result;
	neuron_pkg::fp32_t [neuron_pkg::n_terms-1:0] acts;
	logic [neuron_pkg::idx_w-1:0] term_idx;
	neuron_pkg::fp32_t weight;
	neuron_pkg::fp32_t bias;
	neuron_pkg::fp32_t mul_a;
	neuron_pkg::fp32_t mul_b;
	logic mul_en;
	neuron_pkg::fp32_t product;
	logic mul_valid;
	neuron_pkg::fp32_t add_a;
	neuron_pkg::fp32_t add_b;
	logic add_en;
	neuron_pkg::fp32_t sum;
	logic add_valid;

	neuron_apb_regs neuron_apb_regs_inst (
		.clk(clk),
		.rst_n(rst_n),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.busy(busy),
		.done(done),
		.result(result),
		.start(start),
		.acts(acts)
	);

	neuron_ctrl neuron_ctrl_inst (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.acts(acts),
		.term_idx(term_idx),
		.weight(weight),
		.bias(bias),
		.mul_a(mul_a),
		.mul_b(mul_b),
		.mul_en(mul_en),
		.product(product),
		.mul_valid(mul_valid),
		.add_a(add_a),
		.add_b(add_b),
		.add_en(add_en),
		.sum(sum),
		.add_valid(add_valid),
		.busy(busy),
		.done(done),
		.result(result)
	);

	weight_rom weight_rom_inst (
		.term_idx(term_idx),
		.weight(weight),
		.bias(bias)
	);

	fp_mult fp_mult_inst (
		.clk(clk),
		.rst_n(rst_n),
		.mul_en(mul_en),
		.a(mul_a),
		.b(mul_b),
		.product(product),
		.mul_valid(mul_valid)
	);

	fp_add fp_add_inst (
		.clk(clk),
		.rst_n(rst_n),
		.add_en(add_en),
		.a(add_a),
		.b(add_b),
		.sum(sum),
		.add_valid(add_valid)
	);

endmodule

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		repeat (10) @(posedge clk);
		#2 rst_n = 1'b1;
	end

	// 40 ns period.
	always #20 clk = ~clk;

endmodule

// ==== sim/neuron_tb.sv ====
`timescale 1ns/1ps

module neuron_tb;

	localparam int n_vec = 8;
	localparam int vec_words = neuron_pkg::n_terms + 1;
	localparam int poll_limit = 200;
	localparam int ready_limit = 16;

	logic clk;
	logic rst_n;
	neuron_pkg::apb_req_t apb_req;
	neuron_pkg::apb_rsp_t apb_rsp;
	logic [31:0] vec_mem [0:n_vec*vec_words-1];

	tb_clk_gen tb_clk_gen_inst (
		.clk(clk),
		.rst_n(rst_n)
	);

	neuron_top neuron_top_inst (
		.clk(clk),
		.rst_n(rst_n),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp)
	);

	task automatic stop_run(input string what);
		$display("%s", what);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_fp(input string name, input neuron_pkg::fp32_t expected,
		input neuron_pkg::fp32_t actual);
		if (actual !== expected)
		begin
			$display("Fail at %0t: %s expected %h got %h", $time, name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "result mismatch");
		end
	endtask

	task automatic check_rsp(input string name, input neuron_pkg::apb_rsp_t expected,
		input neuron_pkg::apb_rsp_t actual);
		if (actual.prdata !== expected.prdata || actual.pslverr !== expected.pslverr)
		begin
			$display("Fail at %0t: %s expected prdata %h pslverr %b got prdata %h pslverr %b",
				$time, name, expected.prdata, expected.pslverr, actual.prdata, actual.pslverr);
			$display("Simulation failed");
			$fatal(1, "response mismatch");
		end
	endtask

	// entered and left 2 ns after a rising edge.
	task automatic apb_transfer(input logic write, input logic [7:0] addr,
		input logic [31:0] data, output neuron_pkg::apb_rsp_t rsp);
		int cycles;
		int gap;
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = write;
		apb_req.paddr = addr;
		apb_req.pwdata = data;
		@(posedge clk);
		#2 apb_req.penable = 1'b1;
		cycles = 0;
		@(negedge clk);
		while (!apb_rsp.pready)
		begin
			cycles++;
			if (cycles >= ready_limit)
				stop_run("APB slave never raised pready");
			@(negedge clk);
		end
		rsp = apb_rsp;
		@(posedge clk);
		#2 apb_req = '0;
		gap = $urandom_range(0, 2);
		repeat (gap)
		begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic write_expect(input logic [7:0] addr, input logic [31:0] data,
		input logic err, input string name);
		neuron_pkg::apb_rsp_t rsp;
		neuron_pkg::apb_rsp_t want;
		want = '{prdata: 32'd0, pready: 1'b1, pslverr: err};
		apb_transfer(1'b1, addr, data, rsp);
		check_rsp(name, want, rsp);
	endtask

	task automatic read_expect(input logic [7:0] addr, input logic [31:0] data,
		input logic err, input string name);
		neuron_pkg::apb_rsp_t rsp;
		neuron_pkg::apb_rsp_t want;
		want = '{prdata: data, pready: 1'b1, pslverr: err};
		apb_transfer(1'b0, addr, 32'd0, rsp);
		check_rsp(name, want, rsp);
	endtask

	task automatic poll_status(input logic [31:0] want, input string what);
		neuron_pkg::apb_rsp_t rsp;
		int polls;
		polls = 0;
		apb_transfer(1'b0, neuron_pkg::reg_status, 32'd0, rsp);
		while (rsp.prdata !== want)
		begin
			polls++;
			if (polls >= poll_limit)
				stop_run({"engine status never showed ", what});
			apb_transfer(1'b0, neuron_pkg::reg_status, 32'd0, rsp);
		end
		if (rsp.pslverr !== 1'b0)
			stop_run("status read returned an error");
	endtask

	// writes in a shuffled order, then reads back.
	task automatic load_acts(input int v);
		int order [neuron_pkg::n_terms];
		int j;
		int tmp;
		for (int i = 0; i < neuron_pkg::n_terms; i++)
			order[i] = i;
		for (int i = neuron_pkg::n_terms - 1; i > 0; i--)
		begin
			j = $urandom_range(0, i);
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (int i = 0; i < neuron_pkg::n_terms; i++)
			write_expect(8'(4 * order[i]), vec_mem[v*vec_words+order[i]], 1'b0, "act write");
		for (int i = 0; i < neuron_pkg::n_terms; i++)
			read_expect(8'(4 * i), vec_mem[v*vec_words+i], 1'b0, "act readback");
	endtask

	task automatic run_vector(input int v);
		neuron_pkg::apb_rsp_t rsp;
		load_acts(v);
		write_expect(neuron_pkg::reg_ctrl, 32'd1, 1'b0, "start write");
		// busy with done cleared.
		poll_status(32'h1, "busy");
		if (v == 1)
		begin
			write_expect(8'h0c, 32'hdead_beef, 1'b1, "act write while busy");
			write_expect(neuron_pkg::reg_ctrl, 32'd1, 1'b1, "start while busy");
			read_expect(8'h0c, vec_mem[v*vec_words+3], 1'b0, "act kept while busy");
		end
		poll_status(32'h2, "done");
		apb_transfer(1'b0, neuron_pkg::reg_result, 32'd0, rsp);
		if (rsp.pslverr !== 1'b0)
			stop_run("result read returned an error");
		check_fp("result", neuron_pkg::fp32_t'(vec_mem[v*vec_words+neuron_pkg::n_terms]),
			neuron_pkg::fp32_t'(rsp.prdata));
	endtask

	initial
	begin
		int cycles;
		apb_req = '0;
		void'($urandom(32'h2efa_441a));
		$readmemh("sim/neuron_vectors.txt", vec_mem);
		if ($isunknown(vec_mem[n_vec*vec_words-1]))
			stop_run("vector file is missing or too short");
		cycles = 0;
		while (rst_n !== 1'b1)
		begin
			cycles++;
			if (cycles >= 50)
				stop_run("reset was never released");
			@(posedge clk);
		end
		@(posedge clk);
		#2;
		read_expect(neuron_pkg::reg_status, 32'd0, 1'b0, "status after reset");
		read_expect(neuron_pkg::reg_result, 32'd0, 1'b0, "result after reset");
		// holes in the map.
		read_expect(8'h3c, 32'd0, 1'b1, "unmapped read 0x3c");
		read_expect(8'h42, 32'd0, 1'b1, "unmapped read 0x42");
		read_expect(8'h4c, 32'd0, 1'b1, "unmapped read 0x4c");
		read_expect(8'hfc, 32'd0, 1'b1, "unmapped read 0xfc");
		write_expect(8'h80, 32'h1234_5678, 1'b1, "unmapped write 0x80");
		for (int v = 0; v < n_vec; v++)
			run_vector(v);
		read_expect(8'h50, 32'd0, 1'b1, "unmapped read 0x50");
		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== sim/neuron_vectors.txt ====
// one vector per line: activations 0 to 14, then the expected result word
// zero inputs, relu cut, plain sums, carry, denormal, overflow, cancellation
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3E027431
3F800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3F800000 00000000 3F354B65
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 40000000 00000000 3FA4FCDF
00000000 00000000 00000000 00000000 00000000 3F800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3F800000 00000000 3FA8E7F3
00000001 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00800000 00000000 3E027431
00000000 00000000 00000000 00000000 00000000 7F800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 7F800000 00000000 7F800000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 7E84DE76 FE94AE59 00000000

// ==== src.f ====
hw/neuron_pkg.sv
hw/fp_mult.sv
hw/fp_add.sv
hw/weight_rom.sv
hw/neuron_apb_regs.sv
hw/neuron_ctrl.sv
hw/neuron_top.sv
sim/tb_clk_gen.sv
sim/neuron_tb.sv

// ==== Bender.yml ====
package:
  name: neuron

sources:
  - hw/neuron_pkg.sv
  - hw/fp_mult.sv
  - hw/fp_add.sv
  - hw/weight_rom.sv
  - hw/neuron_apb_regs.sv
  - hw/neuron_ctrl.sv
  - hw/neuron_top.sv
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/neuron_tb.sv
